//--- design/core_region_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_config.svh"

module core_region_mem
(
  input  logic                   clk,
  input  logic                   rst_n,

  // instruction fetch
  input  logic                   instr_req_i,
  input  core_region_pkg::word_t instr_addr_i,
  output logic                   instr_rvalid_o,
  output core_region_pkg::word_t instr_rdata_o,

  // load/store
  input  logic                   lsu_req_i,
  output logic                   lsu_gnt_o,
  output logic                   lsu_rvalid_o,
  input  core_region_pkg::word_t lsu_addr_i,
  input  logic                   lsu_we_i,
  input  core_region_pkg::be_t   lsu_be_i,
  input  core_region_pkg::word_t lsu_wdata_i,
  output core_region_pkg::word_t lsu_rdata_o,

  // external slave
  input  logic                   ext_req_i,
  output logic                   ext_gnt_o,
  output logic                   ext_rvalid_o,
  input  core_region_pkg::word_t ext_addr_i,
  input  logic                   ext_we_i,
  input  core_region_pkg::be_t   ext_be_i,
  input  core_region_pkg::word_t ext_wdata_i,
  output core_region_pkg::word_t ext_rdata_o,

  // system bus master
  output logic                   bus_req_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  output core_region_pkg::word_t bus_addr_o,
  output logic                   bus_we_o,
  output core_region_pkg::be_t   bus_be_o,
  output core_region_pkg::word_t bus_wdata_o,
  input  core_region_pkg::word_t bus_rdata_i
);

  mem_req_if  core_data ();
  ram_port_if ram_b ();

  lsu_router router0
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_addr_i   ( lsu_addr_i   ),
    .lsu_we_i     ( lsu_we_i     ),
    .lsu_be_i     ( lsu_be_i     ),
    .lsu_wdata_i  ( lsu_wdata_i  ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .bus_req_o    ( bus_req_o    ),
    .bus_gnt_i    ( bus_gnt_i    ),
    .bus_rvalid_i ( bus_rvalid_i ),
    .bus_addr_o   ( bus_addr_o   ),
    .bus_we_o     ( bus_we_o     ),
    .bus_be_o     ( bus_be_o     ),
    .bus_wdata_o  ( bus_wdata_o  ),
    .bus_rdata_i  ( bus_rdata_i  ),
    .ram_port     ( core_data    )
  );

  // only the RAM byte offset of the external address matters here
  ram_arbiter arbiter0
  (
    .clk          ( clk                              ),
    .rst_n        ( rst_n                            ),
    .ext_req_i    ( ext_req_i                        ),
    .ext_we_i     ( ext_we_i                         ),
    .ext_addr_i   ( ext_addr_i[`RAM_ADDR_WIDTH+1:0]  ),
    .ext_be_i     ( ext_be_i                         ),
    .ext_wdata_i  ( ext_wdata_i                      ),
    .ext_gnt_o    ( ext_gnt_o                        ),
    .ext_rvalid_o ( ext_rvalid_o                     ),
    .ext_rdata_o  ( ext_rdata_o                      ),
    .core_port    ( core_data                        ),
    .ram          ( ram_b                            )
  );

  unified_mem mem0
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .instr_req_i    ( instr_req_i    ),
    .instr_addr_i   ( instr_addr_i   ),
    .instr_rvalid_o ( instr_rvalid_o ),
    .instr_rdata_o  ( instr_rdata_o  ),
    .port_b         ( ram_b          )
  );

endmodule

`default_nettype wire

//--- design/core_region_pkg.sv
`default_nettype none

`include "core_region_config.svh"

package core_region_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  typedef logic [3:0] be_t;

  // source of the pending load/store response
  typedef enum logic
  {
    TGT_RAM = 1'b0,
    TGT_BUS = 1'b1
  } target_e;

  // byte address inside the unified RAM
  typedef logic [`RAM_ADDR_WIDTH+1:0] ram_addr_t;

endpackage

`default_nettype wire

//--- design/lsu_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_config.svh"

module lsu_router
(
  input  logic                   clk,
  input  logic                   rst_n,

  // load/store port from the core
  input  logic                   lsu_req_i,
  output logic                   lsu_gnt_o,
  output logic                   lsu_rvalid_o,
  input  core_region_pkg::word_t lsu_addr_i,
  input  logic                   lsu_we_i,
  input  core_region_pkg::be_t   lsu_be_i,
  input  core_region_pkg::word_t lsu_wdata_i,
  output core_region_pkg::word_t lsu_rdata_o,

  // system bus
  output logic                   bus_req_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  output core_region_pkg::word_t bus_addr_o,
  output logic                   bus_we_o,
  output core_region_pkg::be_t   bus_be_o,
  output core_region_pkg::word_t bus_wdata_o,
  input  core_region_pkg::word_t bus_rdata_i,

  mem_req_if.master              ram_port
);

  logic is_local;

  core_region_pkg::target_e target_q;
  core_region_pkg::target_e target_d;

  // address decode
  assign is_local = (lsu_addr_i[31:24] == `LOCAL_REGION);

  assign ram_port.req   = lsu_req_i & is_local;
  assign ram_port.addr  = lsu_addr_i;
  assign ram_port.we    = lsu_we_i;
  assign ram_port.be    = lsu_be_i;
  assign ram_port.wdata = lsu_wdata_i;

  assign bus_req_o   = lsu_req_i & ~is_local;
  assign bus_addr_o  = lsu_addr_i;
  assign bus_we_o    = lsu_we_i;
  assign bus_be_o    = lsu_be_i;
  assign bus_wdata_o = lsu_wdata_i;

  // grant of the chosen target, next response source
  always_comb
  begin
    target_d  = target_q;
    lsu_gnt_o = 1'b0;

    if (bus_req_o)
    begin
      lsu_gnt_o = bus_gnt_i;
      if (bus_gnt_i)
      begin
        target_d = core_region_pkg::TGT_BUS;
      end
    end
    else if (ram_port.req)
    begin
      lsu_gnt_o = ram_port.gnt;
      if (ram_port.gnt)
      begin
        target_d = core_region_pkg::TGT_RAM;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      target_q <= core_region_pkg::TGT_RAM;
    end
    else
    begin
      target_q <= target_d;
    end
  end

  // one outstanding access, so target_q names the responder
  always_comb
  begin
    case (target_q)
      core_region_pkg::TGT_BUS:
      begin
        lsu_rvalid_o = bus_rvalid_i;
        lsu_rdata_o  = bus_rdata_i;
      end
      default:
      begin
        lsu_rvalid_o = ram_port.rvalid;
        lsu_rdata_o  = ram_port.rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// request/grant/rvalid memory port
interface mem_req_if;

  logic                   req;
  logic                   gnt;
  logic                   rvalid;
  core_region_pkg::word_t addr;
  logic                   we;
  core_region_pkg::be_t   be;
  core_region_pkg::word_t wdata;
  core_region_pkg::word_t rdata;

  modport master
  (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport slave
  (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

`default_nettype wire

//--- design/ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter
(
  input  logic                       clk,
  input  logic                       rst_n,

  // external port
  input  logic                       ext_req_i,
  input  logic                       ext_we_i,
  input  core_region_pkg::ram_addr_t ext_addr_i,
  input  core_region_pkg::be_t       ext_be_i,
  input  core_region_pkg::word_t     ext_wdata_i,
  output logic                       ext_gnt_o,
  output logic                       ext_rvalid_o,
  output core_region_pkg::word_t     ext_rdata_o,

  // core data port
  mem_req_if.slave                   core_port,

  ram_port_if.requester              ram
);

  core_region_pkg::ram_addr_t core_addr;

  logic rsp_q;
  logic ext_owner_q;

  assign core_addr = core_region_pkg::ram_addr_t'(core_port.addr);

  // external port has fixed priority
  assign ext_gnt_o      = ext_req_i;
  assign core_port.gnt  = core_port.req & ~ext_req_i;

  always_comb
  begin
    ram.en    = ext_req_i | core_port.req;
    ram.addr  = core_addr;
    ram.we    = core_port.we;
    ram.be    = core_port.be;
    ram.wdata = core_port.wdata;

    if (ext_req_i)
    begin
      ram.addr  = ext_addr_i;
      ram.we    = ext_we_i;
      ram.be    = ext_be_i;
      ram.wdata = ext_wdata_i;
    end
  end

  // remember who owns the access now in the RAM
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      rsp_q       <= 1'b0;
      ext_owner_q <= 1'b0;
    end
    else
    begin
      rsp_q       <= ram.en;
      ext_owner_q <= ext_req_i;
    end
  end

  assign ext_rvalid_o     = rsp_q & ext_owner_q;
  assign core_port.rvalid = rsp_q & ~ext_owner_q;

  assign ext_rdata_o     = ext_owner_q ? ram.rdata : '0;
  assign core_port.rdata = ext_owner_q ? '0 : ram.rdata;

endmodule

`default_nettype wire

//--- design/ram_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// plain RAM port with rdata the cycle after en
interface ram_port_if;

  logic                       en;
  core_region_pkg::ram_addr_t addr;
  logic                       we;
  core_region_pkg::be_t       be;
  core_region_pkg::word_t     wdata;
  core_region_pkg::word_t     rdata;

  modport requester
  (
    output en,
    output addr,
    output we,
    output be,
    output wdata,
    input  rdata
  );

  modport memory
  (
    input  en,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- design/unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_config.svh"

module unified_mem
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   instr_req_i,
  input  core_region_pkg::word_t instr_addr_i,
  output logic                   instr_rvalid_o,
  output core_region_pkg::word_t instr_rdata_o,

  ram_port_if.memory             port_b
);

  localparam int unsigned DEPTH = 2 ** `RAM_ADDR_WIDTH;

  core_region_pkg::word_t mem [DEPTH];

  logic                   instr_en;
  logic                   instr_local_q;
  core_region_pkg::word_t instr_rdata_q;
  core_region_pkg::word_t rdata_b_q;

  // fetches outside the local region never touch the array
  assign instr_en = instr_req_i && (instr_addr_i[31:24] == `LOCAL_REGION);

  // port A, read only
  always_ff @(posedge clk)
  begin
    if (instr_en)
    begin
      instr_rdata_q <= mem[instr_addr_i[`RAM_ADDR_WIDTH+1:2]];
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      instr_rvalid_o <= 1'b0;
      instr_local_q  <= 1'b0;
    end
    else
    begin
      instr_rvalid_o <= instr_req_i;
      instr_local_q  <= instr_en;
    end
  end

  assign instr_rdata_o = instr_local_q ? instr_rdata_q : '0;

  // port B, byte writable
  always_ff @(posedge clk)
  begin
    if (port_b.en)
    begin
      if (port_b.we)
      begin
        for (int i = 0; i < 4; i++)
        begin
          if (port_b.be[i])
          begin
            mem[port_b.addr[`RAM_ADDR_WIDTH+1:2]][8*i +: 8] <= port_b.wdata[8*i +: 8];
          end
        end
      end
      rdata_b_q <= mem[port_b.addr[`RAM_ADDR_WIDTH+1:2]];
    end
  end

  assign port_b.rdata = rdata_b_q;

endmodule

`default_nettype wire

//--- dv/core_region_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_config.svh"

module core_region_tb;

  localparam logic [1:0] P_FETCH = 2'd0;
  localparam logic [1:0] P_LSU   = 2'd1;
  localparam logic [1:0] P_EXT   = 2'd2;

  localparam int unsigned DEPTH = 2 ** `RAM_ADDR_WIDTH;

  typedef struct packed
  {
    logic [1:0]             port;
    logic                   we;
    core_region_pkg::word_t addr;
    core_region_pkg::be_t   be;
    core_region_pkg::word_t wdata;
    logic                   conc;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   instr_req_i;
  core_region_pkg::word_t instr_addr_i;
  logic                   instr_rvalid_o;
  core_region_pkg::word_t instr_rdata_o;
  logic                   lsu_req_i;
  logic                   lsu_gnt_o;
  logic                   lsu_rvalid_o;
  core_region_pkg::word_t lsu_addr_i;
  logic                   lsu_we_i;
  core_region_pkg::be_t   lsu_be_i;
  core_region_pkg::word_t lsu_wdata_i;
  core_region_pkg::word_t lsu_rdata_o;
  logic                   ext_req_i;
  logic                   ext_gnt_o;
  logic                   ext_rvalid_o;
  core_region_pkg::word_t ext_addr_i;
  logic                   ext_we_i;
  core_region_pkg::be_t   ext_be_i;
  core_region_pkg::word_t ext_wdata_i;
  core_region_pkg::word_t ext_rdata_o;
  logic                   bus_req_o;
  logic                   bus_gnt_i;
  logic                   bus_rvalid_i;
  core_region_pkg::word_t bus_addr_o;
  logic                   bus_we_o;
  core_region_pkg::be_t   bus_be_o;
  core_region_pkg::word_t bus_wdata_o;
  core_region_pkg::word_t bus_rdata_i;

  row_t                   rows [$];
  core_region_pkg::word_t ref_mem [DEPTH];
  int                     err_count   = 0;
  int                     check_count = 0;
  int                     cycle_count = 0;
  int                     cycle_limit = 0;

  // bus responder state
  logic [31:0]            lfsr_state;
  logic [1:0]             bus_wait;
  logic                   bus_accept;
  logic                   bus_stall;
  core_region_pkg::word_t bus_rsp_addr;
  core_region_pkg::word_t bus_wr_addr;
  core_region_pkg::be_t   bus_wr_be;
  core_region_pkg::word_t bus_wr_data;

  core_region_mem dut0
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .instr_req_i    ( instr_req_i    ),
    .instr_addr_i   ( instr_addr_i   ),
    .instr_rvalid_o ( instr_rvalid_o ),
    .instr_rdata_o  ( instr_rdata_o  ),
    .lsu_req_i      ( lsu_req_i      ),
    .lsu_gnt_o      ( lsu_gnt_o      ),
    .lsu_rvalid_o   ( lsu_rvalid_o   ),
    .lsu_addr_i     ( lsu_addr_i     ),
    .lsu_we_i       ( lsu_we_i       ),
    .lsu_be_i       ( lsu_be_i       ),
    .lsu_wdata_i    ( lsu_wdata_i    ),
    .lsu_rdata_o    ( lsu_rdata_o    ),
    .ext_req_i      ( ext_req_i      ),
    .ext_gnt_o      ( ext_gnt_o      ),
    .ext_rvalid_o   ( ext_rvalid_o   ),
    .ext_addr_i     ( ext_addr_i     ),
    .ext_we_i       ( ext_we_i       ),
    .ext_be_i       ( ext_be_i       ),
    .ext_wdata_i    ( ext_wdata_i    ),
    .ext_rdata_o    ( ext_rdata_o    ),
    .bus_req_o      ( bus_req_o      ),
    .bus_gnt_i      ( bus_gnt_i      ),
    .bus_rvalid_i   ( bus_rvalid_i   ),
    .bus_addr_o     ( bus_addr_o     ),
    .bus_we_o       ( bus_we_o       ),
    .bus_be_o       ( bus_be_o       ),
    .bus_wdata_o    ( bus_wdata_o    ),
    .bus_rdata_i    ( bus_rdata_i    )
  );

  initial
  begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
    begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'hd000_0001 : 32'h0);
  endfunction

  // two random bits, one lfsr step each
  task automatic draw_bus_wait();
    bus_wait[1] = lfsr_state[0];
    lfsr_state  = lfsr_step(lfsr_state);
    bus_wait[0] = lfsr_state[0];
    lfsr_state  = lfsr_step(lfsr_state);
  endtask

  // grant after a random wait, rvalid one cycle after the grant
  assign bus_gnt_i = bus_req_o && (bus_wait == 2'd0);

  initial
  begin
    lfsr_state   = 32'ha78c2994;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = 32'h0;
    bus_accept   = 1'b0;
    bus_stall    = 1'b0;
    bus_rsp_addr = 32'h0;
    bus_wr_addr  = 32'h0;
    bus_wr_be    = 4'h0;
    bus_wr_data  = 32'h0;
    draw_bus_wait();
    forever
    begin
      @(negedge clk);
      bus_accept = bus_req_o && bus_gnt_i;
      bus_stall  = bus_req_o && !bus_gnt_i;
      if (bus_accept)
      begin
        bus_rsp_addr = bus_addr_o;
        if (bus_we_o)
        begin
          bus_wr_addr = bus_addr_o;
          bus_wr_be   = bus_be_o;
          bus_wr_data = bus_wdata_o;
        end
      end
      @(posedge clk);
      #5;
      bus_rvalid_i = bus_accept;
      bus_rdata_i  = bus_accept ? (bus_rsp_addr ^ 32'h5a5a_0000) : 32'h0;
      if (bus_accept)
      begin
        draw_bus_wait();
      end
      else if (bus_stall)
      begin
        bus_wait = bus_wait - 2'd1;
      end
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count = check_count + 1;
    if (got !== exp)
    begin
      err_count = err_count + 1;
      $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic core_region_pkg::word_t merge_bytes(input core_region_pkg::word_t old,
                                                         input core_region_pkg::word_t wdata,
                                                         input core_region_pkg::be_t be);
    core_region_pkg::word_t res;
    res = old;
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
      begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic string port_name(input logic [1:0] port);
    case (port)
      P_FETCH: return "fetch";
      P_LSU:   return "lsu";
      default: return "ext";
    endcase
  endfunction

  task automatic add_row(input logic [1:0] port, input logic we,
                         input core_region_pkg::word_t addr, input core_region_pkg::be_t be,
                         input core_region_pkg::word_t wdata, input logic conc);
    row_t r;
    r.port  = port;
    r.we    = we;
    r.addr  = addr;
    r.be    = be;
    r.wdata = wdata;
    r.conc  = conc;
    rows.push_back(r);
  endtask

  task automatic do_fetch(input core_region_pkg::word_t addr);
    logic                   is_local;
    core_region_pkg::word_t exp;
    is_local = (addr[31:24] == `LOCAL_REGION);
    @(posedge clk);
    #5;
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    exp = is_local ? ref_mem[addr[`RAM_ADDR_WIDTH+1:2]] : 32'h0;
    @(negedge clk);
    check("instr_rvalid_o", 32'(instr_rvalid_o), 32'd0);
    @(posedge clk);
    #5;
    instr_req_i = 1'b0;
    @(negedge clk);
    check("instr_rvalid_o", 32'(instr_rvalid_o), 32'd1);
    check("instr_rdata_o", instr_rdata_o, exp);
  endtask

  task automatic do_lsu(input logic we, input core_region_pkg::word_t addr,
                        input core_region_pkg::be_t be, input core_region_pkg::word_t wdata);
    logic                   is_local;
    int                     waits;
    core_region_pkg::word_t exp;
    is_local = (addr[31:24] == `LOCAL_REGION);
    @(posedge clk);
    #5;
    lsu_req_i   = 1'b1;
    lsu_we_i    = we;
    lsu_addr_i  = addr;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    @(negedge clk);
    // request holds until granted
    while (lsu_gnt_o !== 1'b1)
    begin
      check("bus_req_o", 32'(bus_req_o), 32'(!is_local));
      if (!is_local)
      begin
        check("bus_gnt_i", 32'(bus_gnt_i), 32'd0);
      end
      @(negedge clk);
    end
    if (is_local)
    begin
      if (we)
      begin
        ref_mem[addr[`RAM_ADDR_WIDTH+1:2]] =
          merge_bytes(ref_mem[addr[`RAM_ADDR_WIDTH+1:2]], wdata, be);
      end
      exp = ref_mem[addr[`RAM_ADDR_WIDTH+1:2]];
    end
    else
    begin
      check("bus_gnt_i", 32'(bus_gnt_i), 32'd1);
      check("bus_addr_o", bus_addr_o, addr);
      check("bus_we_o", 32'(bus_we_o), 32'(we));
      check("bus_be_o", 32'(bus_be_o), 32'(be));
      check("bus_wdata_o", bus_wdata_o, wdata);
      exp = addr ^ 32'h5a5a_0000;
    end
    @(posedge clk);
    #5;
    lsu_req_i = 1'b0;
    waits = 1;
    @(negedge clk);
    while (lsu_rvalid_o !== 1'b1)
    begin
      waits = waits + 1;
      @(negedge clk);
    end
    if (is_local)
    begin
      check("lsu_rvalid_o delay", 32'(waits), 32'd1);
    end
    if (!we)
    begin
      check("lsu_rdata_o", lsu_rdata_o, exp);
    end
    else if (!is_local)
    begin
      check("bus write addr", bus_wr_addr, addr);
      check("bus write be", 32'(bus_wr_be), 32'(be));
      check("bus write data", bus_wr_data, wdata);
    end
  endtask

  task automatic do_ext(input logic we, input core_region_pkg::word_t addr,
                        input core_region_pkg::be_t be, input core_region_pkg::word_t wdata,
                        input logic conc);
    core_region_pkg::word_t exp;
    @(posedge clk);
    #5;
    ext_req_i   = 1'b1;
    ext_we_i    = we;
    ext_addr_i  = addr;
    ext_be_i    = be;
    ext_wdata_i = wdata;
    @(negedge clk);
    check("ext_gnt_o", 32'(ext_gnt_o), 32'd1);
    if (conc)
    begin
      check("lsu_gnt_o", 32'(lsu_gnt_o), 32'd0);
    end
    if (we)
    begin
      ref_mem[addr[`RAM_ADDR_WIDTH+1:2]] =
        merge_bytes(ref_mem[addr[`RAM_ADDR_WIDTH+1:2]], wdata, be);
    end
    exp = ref_mem[addr[`RAM_ADDR_WIDTH+1:2]];
    @(posedge clk);
    #5;
    ext_req_i = 1'b0;
    @(negedge clk);
    check("ext_rvalid_o", 32'(ext_rvalid_o), 32'd1);
    if (!we)
    begin
      check("ext_rdata_o", ext_rdata_o, exp);
    end
  endtask

  initial
  begin
    int errs_before;
    rst_n        = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = 32'h0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = 32'h0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = 4'h0;
    lsu_wdata_i  = 32'h0;
    ext_req_i    = 1'b0;
    ext_addr_i   = 32'h0;
    ext_we_i     = 1'b0;
    ext_be_i     = 4'h0;
    ext_wdata_i  = 32'h0;

    // port, we, addr, be, wdata, ext and lsu together
    add_row(P_LSU,   1'b1, 32'h0000_0100, 4'hf, 32'h1122_3344, 1'b0);
    add_row(P_LSU,   1'b1, 32'h0000_0104, 4'hf, 32'ha5a5_a5a5, 1'b0);
    add_row(P_LSU,   1'b1, 32'h0000_0100, 4'h5, 32'haabb_ccdd, 1'b0);
    add_row(P_LSU,   1'b1, 32'h0000_0104, 4'h8, 32'h7700_0000, 1'b0);
    add_row(P_LSU,   1'b0, 32'h0000_0100, 4'hf, 32'h0,         1'b0);
    add_row(P_LSU,   1'b0, 32'h0000_0104, 4'hf, 32'h0,         1'b0);
    add_row(P_LSU,   1'b1, 32'h0000_0108, 4'hf, 32'hcafe_f00d, 1'b0);
    add_row(P_LSU,   1'b1, 32'h0000_0108, 4'h6, 32'h00be_ef00, 1'b0);
    add_row(P_LSU,   1'b0, 32'h0000_0108, 4'hf, 32'h0,         1'b0);
    add_row(P_LSU,   1'b1, 32'h2000_0010, 4'hf, 32'h1234_5678, 1'b0);
    add_row(P_LSU,   1'b0, 32'h2000_0020, 4'hf, 32'h0,         1'b0);
    add_row(P_LSU,   1'b1, 32'h4000_0004, 4'h3, 32'h0000_abcd, 1'b0);
    add_row(P_LSU,   1'b0, 32'h8000_1000, 4'hf, 32'h0,         1'b0);
    add_row(P_EXT,   1'b1, 32'h0000_0200, 4'hf, 32'hdead_beef, 1'b0);
    add_row(P_EXT,   1'b1, 32'h0000_0200, 4'hc, 32'h0102_0000, 1'b0);
    add_row(P_EXT,   1'b0, 32'h0000_0200, 4'hf, 32'h0,         1'b0);
    add_row(P_LSU,   1'b0, 32'h0000_0200, 4'hf, 32'h0,         1'b0);
    add_row(P_FETCH, 1'b0, 32'h0000_0200, 4'hf, 32'h0,         1'b0);
    add_row(P_FETCH, 1'b0, 32'h0000_0100, 4'hf, 32'h0,         1'b0);
    add_row(P_FETCH, 1'b0, 32'h1000_0100, 4'hf, 32'h0,         1'b0);
    add_row(P_EXT,   1'b1, 32'h0000_0300, 4'hf, 32'h0bad_c0de, 1'b1);
    add_row(P_EXT,   1'b0, 32'h0000_0104, 4'hf, 32'h0,         1'b1);
    add_row(P_LSU,   1'b0, 32'h2000_0040, 4'hf, 32'h0,         1'b0);
    add_row(P_LSU,   1'b0, 32'h0000_0108, 4'hf, 32'h0,         1'b0);
    add_row(P_FETCH, 1'b0, 32'h0000_0108, 4'hf, 32'h0,         1'b0);
    add_row(P_EXT,   1'b1, 32'h0000_0104, 4'h1, 32'h0000_00ee, 1'b0);
    add_row(P_FETCH, 1'b0, 32'h0000_0104, 4'hf, 32'h0,         1'b0);
    add_row(P_LSU,   1'b0, 32'h0000_0104, 4'hf, 32'h0,         1'b0);

    cycle_limit = rows.size() * 8 + 100;

    repeat (3) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // idle outputs right after reset
    @(negedge clk);
    errs_before = err_count;
    check("instr_rvalid_o", 32'(instr_rvalid_o), 32'd0);
    check("lsu_rvalid_o", 32'(lsu_rvalid_o), 32'd0);
    check("ext_rvalid_o", 32'(ext_rvalid_o), 32'd0);
    $display("test 0 reset: %s", (err_count == errs_before) ? "ok" : "error");

    foreach (rows[i])
    begin
      errs_before = err_count;
      case (rows[i].port)
        P_FETCH:
        begin
          do_fetch(rows[i].addr);
        end
        P_LSU:
        begin
          do_lsu(rows[i].we, rows[i].addr, rows[i].be, rows[i].wdata);
        end
        default:
        begin
          if (rows[i].conc)
          begin
            // lsu reads the same word while ext holds the RAM
            fork
              do_ext(rows[i].we, rows[i].addr, rows[i].be, rows[i].wdata, 1'b1);
              do_lsu(1'b0, rows[i].addr, 4'hf, 32'h0);
            join
          end
          else
          begin
            do_ext(rows[i].we, rows[i].addr, rows[i].be, rows[i].wdata, 1'b0);
          end
        end
      endcase
      $display("test %0d %s %s addr %h%s: %s", i + 1, port_name(rows[i].port),
               rows[i].we ? "write" : "read", rows[i].addr,
               rows[i].conc ? " with lsu" : "",
               (err_count == errs_before) ? "ok" : "error");
    end

    $display("%0d tests, %0d checks, %0d errors", rows.size() + 1, check_count, err_count);
    if (err_count == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/core_region_pkg.sv
design/mem_req_if.sv
design/ram_port_if.sv
design/unified_mem.sv
design/ram_arbiter.sv
design/lsu_router.sv
design/core_region_mem.sv
dv/core_region_tb.sv

//--- include/core_region_config.svh
`ifndef CORE_REGION_CONFIG_SVH
`define CORE_REGION_CONFIG_SVH

// word address width of the unified RAM (4096 words)
`define RAM_ADDR_WIDTH 12

// address bits 31:24 that select the local RAM
`define LOCAL_REGION 8'h00

`endif

//--- run.sh
#!/bin/sh
# build and run the core region testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=core_region_sim

rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/1ps -f files.f \
  --top-module core_region_tb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi

exit 0
